//--- design/cn_drive_pkg.sv
`default_nettype none

package cn_drive_pkg;

    localparam int CURRENT_W = 16;
    localparam int DRIVE_W   = 32;
    localparam int SCALER_W  = 3;
    localparam int PRESS_W   = 4;

    typedef logic [CURRENT_W-1:0] current_t;   // integer input current
    typedef logic [DRIVE_W-1:0]   drive_t;     // latched cn drive
    typedef logic [SCALER_W-1:0]  scaler_t;    // button gain 0..7
    typedef logic [PRESS_W-1:0]   press_cnt_t; // level changes 0..14

    localparam press_cnt_t PRESS_CNT_MAX = 4'd14; // wraps to 0 after this

    // default left shifts of the two drive terms
    localparam int SPINDLE_SHIFT_DEF = 8;
    localparam int EXTRA_SHIFT_DEF   = 10;

    // last tick-sampled level of the button
    typedef enum logic {
        BTN_LOW  = 1'b0,
        BTN_HIGH = 1'b1
    } btn_state_e;

    // everything the drive computation consumes
    typedef struct packed {
        current_t spindle; // spindle afferent current
        current_t extra;   // extra cortical drive
        scaler_t  scaler;  // button gain scaler
    } drive_in_t;

endpackage

`default_nettype wire

//--- design/cn_host_pkg.sv
`default_nettype none

package cn_host_pkg;

    typedef logic [31:0] host_word_t;   // {ep02, ep01} data word
    typedef logic [15:0] trig_vec_t;    // one trigger bit per register
    typedef logic [7:0]  rd_addr_t;     // wire-out address
    typedef logic [15:0] rd_data_t;     // wire-out data half

    // trigger bit positions on the ep50 vector
    localparam int TRIG_TICK_DIV    = 7;
    localparam int TRIG_EXTRA_DRIVE = 8;

    // wire-out map, lo/hi halves on consecutive addresses
    localparam rd_addr_t ADDR_SCALED_LO  = 8'h20;
    localparam rd_addr_t ADDR_SCALED_HI  = 8'h21;
    localparam rd_addr_t ADDR_SPINDLE_LO = 8'h24;
    localparam rd_addr_t ADDR_SPINDLE_HI = 8'h25;
    localparam rd_addr_t ADDR_DRIVE_LO   = 8'h26;
    localparam rd_addr_t ADDR_DRIVE_HI   = 8'h27;
    localparam rd_addr_t ADDR_EXTRA_LO   = 8'h28;
    localparam rd_addr_t ADDR_EXTRA_HI   = 8'h29;
    localparam rd_addr_t ADDR_TICKDIV_LO = 8'h2E;
    localparam rd_addr_t ADDR_TICKDIV_HI = 8'h2F;

    localparam host_word_t TICK_DIV_RESET = 32'd381; // real-time tick period minus one

    typedef struct packed {
        host_word_t              tick_div;    // tick period minus one
        cn_drive_pkg::current_t  extra_drive; // extra cortical drive
    } param_regs_t;

endpackage

`default_nettype wire

//--- design/trig_param_decode.sv
`default_nettype none
`timescale 1ns/10ps

module trig_param_decode (
    input  wire                       ep50trig,
    input  wire                       reset_global,
    input  cn_host_pkg::trig_vec_t    i_trig,      // one bit per register
    input  cn_host_pkg::host_word_t   i_host_data, // value for every set bit
    output cn_host_pkg::param_regs_t  o_params,
    output logic                      o_tick_div_load
);

    logic ld_tick_div;
    logic ld_extra;

    assign ld_tick_div = i_trig[cn_host_pkg::TRIG_TICK_DIV];
    assign ld_extra    = i_trig[cn_host_pkg::TRIG_EXTRA_DRIVE];

    // lands on the same edge as the register, so the divider sees
    // the new period together with the restart
    assign o_tick_div_load = ld_tick_div;

    // clock divider period
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_params.tick_div <= cn_host_pkg::TICK_DIV_RESET; // real-time speed
        end else if (ld_tick_div) begin
            o_params.tick_div <= i_host_data;
        end
    end

    // extra cortical drive, only the low half is a current
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_params.extra_drive <= '0;
        end else if (ld_extra) begin
            o_params.extra_drive <= i_host_data[cn_drive_pkg::CURRENT_W-1:0];
        end
    end

    // remaining trigger bits have no register behind them

    // a strobe must come with a clean data word
    a_host_data_known: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (|i_trig) |-> !$isunknown(i_host_data)
    ) else $error("host data has unknown bits during a trigger");

endmodule

`default_nettype wire

//--- design/sim_tick_gen.sv
`default_nettype none
`timescale 1ns/10ps

module sim_tick_gen (
    input  wire                      ep50trig,
    input  wire                      reset_global,
    input  cn_host_pkg::host_word_t  i_tick_div, // period minus one
    input  wire                      i_restart,  // divisor rewritten
    output logic                     o_sim_tick
);

    cn_host_pkg::host_word_t cnt_q;

    assign o_sim_tick = (cnt_q == i_tick_div); // last count of the period

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cnt_q <= '0;
        end else if (i_restart) begin
            cnt_q <= '0;              // fresh period after a write
        end else if (cnt_q >= i_tick_div) begin
            cnt_q <= '0;              // wrap at end of period
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // back-to-back ticks only when the period is a single cycle
    a_tick_one_cycle: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (o_sim_tick && !i_restart && (i_tick_div != '0)) |=> !o_sim_tick
    ) else $error("sim tick held high over two cycles");

endmodule

`default_nettype wire

//--- design/gain_button_scaler.sv
`default_nettype none
`timescale 1ns/10ps

module gain_button_scaler (
    input  wire                    ep50trig,
    input  wire                    reset_global,
    input  wire                    i_sim_tick,
    input  wire                    i_button,   // raw board button
    output cn_drive_pkg::scaler_t  o_scaler
);

    cn_drive_pkg::btn_state_e  btn_now;  // newest tick sample
    cn_drive_pkg::btn_state_e  btn_prev; // sample one tick older
    cn_drive_pkg::press_cnt_t  press_cnt;
    logic                      level_chg;

    assign level_chg = (btn_now != btn_prev);

    // two-deep sample history, advanced only on the tick
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_now  <= cn_drive_pkg::BTN_LOW;
            btn_prev <= cn_drive_pkg::BTN_LOW;
        end else if (i_sim_tick) begin
            btn_now  <= i_button ? cn_drive_pkg::BTN_HIGH : cn_drive_pkg::BTN_LOW;
            btn_prev <= btn_now;
        end
    end

    // each held level change is seen on exactly one tick
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            press_cnt <= '0;
        end else if (i_sim_tick && level_chg) begin
            if (press_cnt == cn_drive_pkg::PRESS_CNT_MAX)
                press_cnt <= '0;             // 14 -> 0
            else
                press_cnt <= press_cnt + 1'b1;
        end
    end

    assign o_scaler = press_cnt[cn_drive_pkg::PRESS_W-1:1]; // two changes per gain step

    a_press_cnt_range: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        press_cnt <= cn_drive_pkg::PRESS_CNT_MAX
    ) else $error("button press count out of range");

endmodule

`default_nettype wire

//--- design/cn_drive_compute.sv
`default_nettype none
`timescale 1ns/10ps

module cn_drive_compute #(
    parameter int SPINDLE_SHIFT = cn_drive_pkg::SPINDLE_SHIFT_DEF,
    parameter int EXTRA_SHIFT   = cn_drive_pkg::EXTRA_SHIFT_DEF
) (
    input  wire                      ep50trig,
    input  wire                      reset_global,
    input  wire                      i_sim_tick,
    input  cn_drive_pkg::drive_in_t  i_in,
    output cn_drive_pkg::drive_t     o_drive
);

    localparam bit DEFAULT_SHIFTS = (SPINDLE_SHIFT <= cn_drive_pkg::SPINDLE_SHIFT_DEF) &&
                                    (EXTRA_SHIFT <= cn_drive_pkg::EXTRA_SHIFT_DEF);

    cn_drive_pkg::drive_t spindle_term;
    cn_drive_pkg::drive_t extra_term;
    cn_drive_pkg::drive_t drive_next;

    // widen before shifting so no bits fall off the top
    always_comb begin
        spindle_term = cn_drive_pkg::drive_t'(i_in.spindle) << SPINDLE_SHIFT;
        extra_term   = cn_drive_pkg::drive_t'(i_in.extra) << EXTRA_SHIFT;
        // sensory term plus gain, then the cortical drive on top
        drive_next   = spindle_term + cn_drive_pkg::drive_t'(i_in.scaler) + extra_term;
    end

    // one new drive value per simulation step
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_drive <= '0;
        end else if (i_sim_tick) begin
            o_drive <= drive_next;
        end
    end

    // 16-bit currents at the default shifts stay well below bit 31,
    // so a set msb after a tick means a term was mis-sized upstream
    a_drive_msb_clear: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (i_sim_tick && DEFAULT_SHIFTS) |=> !o_drive[cn_drive_pkg::DRIVE_W-1]
    ) else $error("drive msb set under default shifts");

endmodule

`default_nettype wire

//--- design/host_readout.sv
`default_nettype none
`timescale 1ns/10ps

module host_readout (
    input  wire                       ep50trig,
    input  wire                       reset_global,
    input  cn_host_pkg::rd_addr_t     i_rd_addr,
    input  cn_host_pkg::param_regs_t  i_params,
    input  cn_drive_pkg::drive_in_t   i_in,
    input  cn_drive_pkg::drive_t      i_drive,
    output cn_host_pkg::rd_data_t     o_rd_data
);

    cn_host_pkg::rd_data_t rd_next;

    always_comb begin
        case (i_rd_addr)
            cn_host_pkg::ADDR_SCALED_LO:  rd_next = cn_host_pkg::rd_data_t'(i_in.scaler);
            cn_host_pkg::ADDR_SPINDLE_LO: rd_next = i_in.spindle;
            cn_host_pkg::ADDR_DRIVE_LO:   rd_next = i_drive[15:0];
            cn_host_pkg::ADDR_DRIVE_HI:   rd_next = i_drive[31:16];
            cn_host_pkg::ADDR_EXTRA_LO:   rd_next = i_params.extra_drive;
            cn_host_pkg::ADDR_TICKDIV_LO: rd_next = i_params.tick_div[15:0];
            cn_host_pkg::ADDR_TICKDIV_HI: rd_next = i_params.tick_div[31:16];
            default:                      rd_next = '0; // 16-bit values have a zero hi half
        endcase
    end

    // one cycle from address to data
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global)
            o_rd_data <= '0;
        else
            o_rd_data <= rd_next;
    end

endmodule

`default_nettype wire

//--- design/cn_drive_top.sv
`default_nettype none
`timescale 1ns/10ps

module cn_drive_top #(
    parameter int SPINDLE_SHIFT = cn_drive_pkg::SPINDLE_SHIFT_DEF,
    parameter int EXTRA_SHIFT   = cn_drive_pkg::EXTRA_SHIFT_DEF
) (
    input  wire                      ep50trig,     // system clock
    input  wire                      reset_global, // async, active high
    input  cn_host_pkg::trig_vec_t   i_trig,
    input  cn_host_pkg::host_word_t  i_host_data,
    input  cn_host_pkg::rd_addr_t    i_rd_addr,
    input  cn_drive_pkg::current_t   i_spindle,
    input  wire                      i_button,
    output cn_host_pkg::rd_data_t    o_rd_data,
    output cn_drive_pkg::drive_t     o_drive,
    output cn_drive_pkg::scaler_t    o_scaler,
    output logic                     o_sim_tick
);

    cn_host_pkg::param_regs_t  params;
    cn_drive_pkg::drive_in_t   drive_in;
    logic                      tick_div_load;

    // decode: host parameter registers
    trig_param_decode u_decode (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_trig          (i_trig),
        .i_host_data     (i_host_data),
        .o_params        (params),
        .o_tick_div_load (tick_div_load)
    );

    sim_tick_gen u_tick (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick_div   (params.tick_div),
        .i_restart    (tick_div_load), // new period starts from 0
        .o_sim_tick   (o_sim_tick)
    );

    gain_button_scaler u_scaler (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (o_sim_tick),
        .i_button     (i_button),
        .o_scaler     (o_scaler)
    );

    always_comb begin
        drive_in.spindle = i_spindle;
        drive_in.extra   = params.extra_drive;
        drive_in.scaler  = o_scaler;
    end

    // execute: drive latched once per tick
    cn_drive_compute #(
        .SPINDLE_SHIFT (SPINDLE_SHIFT),
        .EXTRA_SHIFT   (EXTRA_SHIFT)
    ) u_compute (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (o_sim_tick),
        .i_in         (drive_in),
        .o_drive      (o_drive)
    );

    // result: wire-out readback
    host_readout u_readout (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_rd_addr    (i_rd_addr),
        .i_params     (params),
        .i_in         (drive_in),
        .i_drive      (o_drive),
        .o_rd_data    (o_rd_data)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #(PERIOD_NS / 2) o_clk = ~o_clk; // 50% duty, free running

endmodule

`default_nettype wire

//--- verif/tb_cn_drive.sv
`default_nettype none
`timescale 1ns/10ps

module tb_cn_drive;

    localparam int TICK_TIMEOUT = 1000; // tick wait limit in cycles (reset period is 382)

    logic                     ep50trig;
    logic                     reset_global;
    cn_host_pkg::trig_vec_t   trig;
    cn_host_pkg::host_word_t  host_data;
    cn_host_pkg::rd_addr_t    rd_addr;
    cn_drive_pkg::current_t   spindle;
    logic                     button;
    cn_host_pkg::rd_data_t    rd_data;
    cn_drive_pkg::drive_t     drive;
    cn_drive_pkg::scaler_t    scaler;
    logic                     sim_tick;

    integer                 seed;
    int                     errors;
    int                     checks;
    int                     tests;
    int                     total_changes; // button level changes since reset
    cn_drive_pkg::scaler_t  exp_scaler;    // model of the gain scaler
    logic                   timed_out;

    tb_clock_gen #(.PERIOD_NS(4)) clk_i (.o_clk(ep50trig));

    cn_drive_top #(
        .SPINDLE_SHIFT (cn_drive_pkg::SPINDLE_SHIFT_DEF),
        .EXTRA_SHIFT   (cn_drive_pkg::EXTRA_SHIFT_DEF)
    ) dut_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (trig),
        .i_host_data  (host_data),
        .i_rd_addr    (rd_addr),
        .i_spindle    (spindle),
        .i_button     (button),
        .o_rd_data    (rd_data),
        .o_drive      (drive),
        .o_scaler     (scaler),
        .o_sim_tick   (sim_tick)
    );

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic end_test(input string name, input int errors_at_start);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s had %0d mismatches", name, errors - errors_at_start);
        end
    endtask

    // returns on the falling edge of a tick cycle and counts the falling edges passed
    task automatic wait_tick(input string name, output int cycles);
        cycles = 0;
        if (!timed_out) begin
            @(negedge ep50trig);
            cycles = 1;
            while (sim_tick !== 1'b1 && cycles < TICK_TIMEOUT) begin
                @(negedge ep50trig);
                cycles++;
            end
            if (sim_tick !== 1'b1) begin
                errors++;
                timed_out = 1'b1; // later waits return at once
                $display("%s: timeout waiting for sim tick", name);
            end
        end
    endtask

    // one-cycle trigger strobe that the register takes on the next edge
    task automatic write_param(input int bit_idx, input cn_host_pkg::host_word_t value);
        @(posedge ep50trig);
        trig      <= cn_host_pkg::trig_vec_t'(1) << bit_idx;
        host_data <= value;
        @(posedge ep50trig);
        trig      <= '0;
    endtask

    task automatic read_word(input cn_host_pkg::rd_addr_t addr,
                             output cn_host_pkg::rd_data_t data);
        @(posedge ep50trig);
        rd_addr <= addr;
        @(posedge ep50trig); // readout register takes the address here
        @(negedge ep50trig);
        data = rd_data;
    endtask

    task automatic test_reset_values();
        cn_host_pkg::rd_data_t d;
        int start;
        start = errors;
        @(negedge ep50trig);
        check("reset_values", 32'd0, drive);
        check("reset_values", 32'd0, 32'(scaler));
        check("reset_values", 32'd0, 32'(sim_tick));
        read_word(cn_host_pkg::ADDR_TICKDIV_LO, d);
        check("reset_values", 32'd381, 32'(d));
        read_word(cn_host_pkg::ADDR_TICKDIV_HI, d);
        check("reset_values", 32'd0, 32'(d));
        end_test("reset_values", start);
    endtask

    task automatic test_param_readback();
        cn_host_pkg::host_word_t word;
        cn_host_pkg::rd_data_t   d;
        int start;
        start = errors;
        word = $random(seed);
        write_param(cn_host_pkg::TRIG_EXTRA_DRIVE, word);
        read_word(cn_host_pkg::ADDR_EXTRA_LO, d);
        check("param_readback", 32'(word[15:0]), 32'(d)); // only the low half is kept
        read_word(cn_host_pkg::ADDR_EXTRA_HI, d);
        check("param_readback", 32'd0, 32'(d));
        read_word(8'h3c, d);                                // unmapped
        check("param_readback", 32'd0, 32'(d));
        end_test("param_readback", start);
    endtask

    task automatic test_tick_period();
        int start;
        int gap;
        start = errors;
        write_param(cn_host_pkg::TRIG_TICK_DIV, 32'd5);
        wait_tick("tick_period", gap); // first period counts from 0 after the restart
        check("tick_period", 32'd6, gap);
        for (int p = 0; p < 2; p++) begin
            wait_tick("tick_period", gap);
            check("tick_period", 32'd6, gap); // tick_div + 1
        end
        end_test("tick_period", start);
    endtask

    task automatic test_button_scaler(input int k);
        int start;
        int cyc;
        start = errors;
        for (int i = 0; i < k; i++) begin
            @(posedge ep50trig);
            button <= ~button;
            total_changes++;
            for (int t = 0; t < 3; t++) begin
                wait_tick("button_scaler", cyc); // hold the level for 3 ticks
            end
        end
        exp_scaler = cn_drive_pkg::scaler_t'((total_changes % 15) / 2); // count wraps 14 -> 0
        check($sformatf("button_scaler_k%0d", k), 32'(exp_scaler), 32'(scaler));
        end_test($sformatf("button_scaler_k%0d", k), start);
    endtask

    task automatic test_drive_formula();
        cn_host_pkg::host_word_t word;
        cn_drive_pkg::current_t  sp;
        cn_drive_pkg::drive_t    expected;
        cn_host_pkg::rd_data_t   d;
        int start;
        int cyc;
        start = errors;
        for (int r = 0; r < 2; r++) begin
            word = $random(seed);
            sp   = cn_drive_pkg::current_t'($random(seed));
            write_param(cn_host_pkg::TRIG_EXTRA_DRIVE, word);
            @(posedge ep50trig);
            spindle <= sp;
            wait_tick("drive_formula", cyc);
            @(negedge ep50trig); // drive latched on the tick edge
            expected = (32'(sp) << 8) + 32'(exp_scaler) + (32'(word[15:0]) << 10);
            check("drive_formula", expected, drive);
            read_word(cn_host_pkg::ADDR_DRIVE_LO, d);
            check("drive_formula", 32'(expected[15:0]), 32'(d));
            read_word(cn_host_pkg::ADDR_DRIVE_HI, d);
            check("drive_formula", 32'(expected[31:16]), 32'(d));
        end
        end_test("drive_formula", start);
    endtask

    initial begin
        seed          = 32'h3009;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        total_changes = 0;
        exp_scaler    = '0;
        timed_out     = 1'b0;
        reset_global <= 1'b1;
        trig         <= '0;
        host_data    <= '0;
        rd_addr      <= '0;
        spindle      <= '0;
        button       <= 1'b0;
        repeat (8) @(posedge ep50trig);
        reset_global <= 1'b0;

        test_reset_values();
        test_param_readback();
        test_tick_period();   // leaves a 6-cycle tick for the rest
        test_button_scaler(3);
        test_button_scaler(16);
        test_drive_formula();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
design/cn_drive_pkg.sv
design/cn_host_pkg.sv
design/trig_param_decode.sv
design/sim_tick_gen.sv
design/gain_button_scaler.sv
design/cn_drive_compute.sv
design/host_readout.sv
design/cn_drive_top.sv
verif/tb_clock_gen.sv
verif/tb_cn_drive.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/10ps
TOP        = tb_cn_drive
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Test failed
PASS_MSG   = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/10ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
